// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import alu_types_pkg::*;
(
    input  aluop_t          op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu_types_pkg.sv ====
`default_nettype none

package alu_types_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluop_t;

    typedef enum logic {
        A_RS1,
        A_PC
    } alu_a_sel_t;

    typedef enum logic {
        B_RS2,
        B_IMM
    } alu_b_sel_t;

    // Source of the register write value
    typedef enum logic [1:0] {
        W_ALU,
        W_PC4,
        W_IMM
    } wsel_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        aluop_t                alu_op;
        alu_a_sel_t            a_sel;
        alu_b_sel_t            b_sel;
        wsel_t                 w_sel;
        logic                  wen;
        logic                  illegal;
        logic                  halt;
    } ctrl_t;

    // Issue to execute record
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       imm;
        aluop_t                alu_op;
        wsel_t                 w_sel;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic                  illegal;
        logic                  halt;
    } id_ex_t;

    // Execute to write-back record
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       data;
        logic                  illegal;
        logic                  halt;
    } ex_wb_t;

endpackage

`default_nettype wire

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import rv32i_types_pkg::*;
    import alu_types_pkg::*;
(
    input  logic [31:0] instr_i,
    output ctrl_t       ctrl_o
);

    rtype_t  r_fmt;
    itype_t  i_fmt;
    utype_t  u_fmt;
    opcode_t opcode;
    aluop_t  alu_op;

    logic is_imm;
    logic is_reg;
    logic shift_r;
    logic add_sub;
    logic op_sll;
    logic op_sra;
    logic op_srl;
    logic op_add;
    logic op_sub;
    logic op_and;
    logic op_or;
    logic op_xor;
    logic op_slt;
    logic op_sltu;

    // One view of the word per format
    assign r_fmt  = rtype_t'(instr_i);
    assign i_fmt  = itype_t'(instr_i);
    assign u_fmt  = utype_t'(instr_i);
    assign opcode = opcode_t'(instr_i[6:0]);

    assign is_imm = (opcode == IMMED);
    assign is_reg = (opcode == REGREG);

    assign shift_r = (is_imm && i_fmt.funct3 == SRI) || (is_reg && r_fmt.funct3 == SR);
    assign add_sub = is_reg && (r_fmt.funct3 == ADDSUB);

    // Bit 30 picks SUB and SRA/SRAI
    assign op_sll  = (is_imm && i_fmt.funct3 == SLLI) || (is_reg && r_fmt.funct3 == SLL);
    assign op_sra  = shift_r && instr_i[30];
    assign op_srl  = shift_r && !instr_i[30];
    assign op_add  = (is_imm && i_fmt.funct3 == ADDI) || (add_sub && !instr_i[30]) ||
                     (opcode == AUIPC) || (opcode == LOAD) || (opcode == STORE);
    assign op_sub  = add_sub && instr_i[30];
    assign op_and  = (is_imm && i_fmt.funct3 == ANDI) || (is_reg && r_fmt.funct3 == AND);
    assign op_or   = (is_imm && i_fmt.funct3 == ORI) || (is_reg && r_fmt.funct3 == OR);
    assign op_xor  = (is_imm && i_fmt.funct3 == XORI) || (is_reg && r_fmt.funct3 == XOR);
    assign op_slt  = (is_imm && i_fmt.funct3 == SLTI) || (is_reg && r_fmt.funct3 == SLT);
    assign op_sltu = (is_imm && i_fmt.funct3 == SLTIU) || (is_reg && r_fmt.funct3 == SLTU);

    // Shifts first, then arithmetic, then logic and compares
    always_comb begin
        if (op_sll) alu_op = ALU_SLL;
        else if (op_sra) alu_op = ALU_SRA;
        else if (op_srl) alu_op = ALU_SRL;
        else if (op_add) alu_op = ALU_ADD;
        else if (op_sub) alu_op = ALU_SUB;
        else if (op_and) alu_op = ALU_AND;
        else if (op_or) alu_op = ALU_OR;
        else if (op_xor) alu_op = ALU_XOR;
        else if (op_slt) alu_op = ALU_SLT;
        else if (op_sltu) alu_op = ALU_SLTU;
        else alu_op = ALU_ADD;
    end

    always_comb begin
        ctrl_o.rs1    = r_fmt.rs1;
        ctrl_o.rs2    = r_fmt.rs2;
        ctrl_o.rd     = r_fmt.rd;
        ctrl_o.alu_op = alu_op;
        ctrl_o.halt   = (instr_i == HALT_INSN);

        // U immediate for upper-immediate ops, sign-extended I otherwise
        if (opcode == LUI || opcode == AUIPC) begin
            ctrl_o.imm = {u_fmt.imm31_12, 12'b0};
        end else begin
            ctrl_o.imm = {{(XLEN-12){i_fmt.imm11_00[11]}}, i_fmt.imm11_00};
        end

        ctrl_o.a_sel = (opcode == AUIPC) ? A_PC : A_RS1;
        ctrl_o.b_sel = is_reg ? B_RS2 : B_IMM;

        case (opcode)
            JAL, JALR: ctrl_o.w_sel = W_PC4;
            LUI:       ctrl_o.w_sel = W_IMM;
            default:   ctrl_o.w_sel = W_ALU;
        endcase

        case (opcode)
            IMMED, REGREG, LUI, AUIPC, JAL, JALR: ctrl_o.wen = 1'b1;
            default:                              ctrl_o.wen = 1'b0;
        endcase

        // Known opcodes without a result decode as legal
        case (opcode)
            REGREG:
                ctrl_o.illegal = r_fmt.funct7[0];
            LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, IMMED, MISCMEM, SYSTEM:
                ctrl_o.illegal = 1'b0;
            default:
                ctrl_o.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import alu_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  id_ex_t          id_ex_i,
    output logic [XLEN-1:0] ex_fwd_data_o,
    output ex_wb_t          ex_wb_o
);

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;

    alu u_alu (
        .op_i     (id_ex_i.alu_op),
        .a_i      (id_ex_i.operand_a),
        .b_i      (id_ex_i.operand_b),
        .result_o (alu_result)
    );

    // Jumps link to the next instruction
    always_comb begin
        case (id_ex_i.w_sel)
            W_PC4:   wb_data = id_ex_i.pc + XLEN'(4);
            W_IMM:   wb_data = id_ex_i.imm;
            default: wb_data = alu_result;
        endcase
    end

    assign ex_fwd_data_o = wb_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_wb_o <= '0;
        end else begin
            ex_wb_o.valid   <= id_ex_i.valid;
            ex_wb_o.rd      <= id_ex_i.rd;
            // Illegal words leave the register file untouched
            ex_wb_o.wen     <= id_ex_i.valid && id_ex_i.wen && !id_ex_i.illegal;
            ex_wb_o.data    <= wb_data;
            ex_wb_o.illegal <= id_ex_i.illegal;
            ex_wb_o.halt    <= id_ex_i.halt;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (rst_i)
        !$isunknown(ex_wb_o.valid));

endmodule

`default_nettype wire

// ==== hw/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import alu_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       ex_fwd_data_i,
    output logic [REG_ADDR_W-1:0] rf_rs1_o,
    output logic [REG_ADDR_W-1:0] rf_rs2_o,
    input  logic [XLEN-1:0]       rf_rdata1_i,
    input  logic [XLEN-1:0]       rf_rdata2_i,
    output id_ex_t                id_ex_o
);

    ctrl_t           ctrl;
    logic            ex_writes;
    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    id_ex_t          id_ex_d;

    control_unit u_control_unit (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    assign rf_rs1_o = ctrl.rs1;
    assign rf_rs2_o = ctrl.rs2;

    // Execute stage holds a result this instruction may need
    assign ex_writes = id_ex_o.valid && id_ex_o.wen && !id_ex_o.illegal;
    assign fwd_rs1   = ex_writes && ctrl.rs1 != '0 && id_ex_o.rd == ctrl.rs1;
    assign fwd_rs2   = ex_writes && ctrl.rs2 != '0 && id_ex_o.rd == ctrl.rs2;

    // Older results in write-back arrive through the register file bypass
    assign rs1_val = fwd_rs1 ? ex_fwd_data_i : rf_rdata1_i;
    assign rs2_val = fwd_rs2 ? ex_fwd_data_i : rf_rdata2_i;

    always_comb begin
        id_ex_d.valid     = instr_valid_i;
        id_ex_d.pc        = pc_i;
        id_ex_d.operand_a = (ctrl.a_sel == A_PC) ? pc_i : rs1_val;
        id_ex_d.operand_b = (ctrl.b_sel == B_IMM) ? ctrl.imm : rs2_val;
        id_ex_d.imm       = ctrl.imm;
        id_ex_d.alu_op    = ctrl.alu_op;
        id_ex_d.w_sel     = ctrl.w_sel;
        id_ex_d.rd        = ctrl.rd;
        // Writes to x0 are dropped here
        id_ex_d.wen       = instr_valid_i && ctrl.wen && ctrl.rd != '0;
        id_ex_d.illegal   = instr_valid_i && ctrl.illegal;
        id_ex_d.halt      = instr_valid_i && ctrl.halt;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
        id_ex_o.valid |-> !(id_ex_o.wen && id_ex_o.rd == '0));

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import alu_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       wdata_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // Write-through so a same-cycle write is visible to the reader
    always_comb begin
        if (rs1_i == '0) rdata1_o = '0;
        else if (we_i && rd_i == rs1_i) rdata1_o = wdata_i;
        else rdata1_o = regs[rs1_i];

        if (rs2_i == '0) rdata2_o = '0;
        else if (we_i && rd_i == rs2_i) rdata2_o = wdata_i;
        else rdata2_o = regs[rs2_i];
    end

    a_x0_zero: assert property (@(posedge clk)
        (rs1_i == '0 |-> rdata1_o == '0) and (rs2_i == '0 |-> rdata2_o == '0));

endmodule

`default_nettype wire

// ==== hw/rv32i_exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_exec_pipe
    import alu_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic                  wb_valid_o,
    output logic                  wb_wen_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  illegal_o,
    output logic                  halt_o
);

    id_ex_t                id_ex;
    ex_wb_t                ex_wb;
    logic [XLEN-1:0]       ex_fwd_data;
    logic [REG_ADDR_W-1:0] rf_rs1;
    logic [REG_ADDR_W-1:0] rf_rs2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;

    issue_stage u_issue_stage (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .ex_fwd_data_i (ex_fwd_data),
        .rf_rs1_o      (rf_rs1),
        .rf_rs2_o      (rf_rs2),
        .rf_rdata1_i   (rf_rdata1),
        .rf_rdata2_i   (rf_rdata2),
        .id_ex_o       (id_ex)
    );

    execute_stage u_execute_stage (
        .clk           (clk),
        .rst_i         (rst_i),
        .id_ex_i       (id_ex),
        .ex_fwd_data_o (ex_fwd_data),
        .ex_wb_o       (ex_wb)
    );

    // Write-back record commits here; wen is already qualified by valid
    reg_file u_reg_file (
        .clk      (clk),
        .rst_i    (rst_i),
        .rs1_i    (rf_rs1),
        .rs2_i    (rf_rs2),
        .we_i     (ex_wb.wen),
        .rd_i     (ex_wb.rd),
        .wdata_i  (ex_wb.data),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    assign wb_valid_o = ex_wb.valid;
    assign wb_wen_o   = ex_wb.wen;
    assign wb_rd_o    = ex_wb.rd;
    assign wb_data_o  = ex_wb.data;
    assign illegal_o  = ex_wb.illegal;
    assign halt_o     = ex_wb.halt;

endmodule

`default_nettype wire

// ==== hw/rv32i_types_pkg.sv ====
`default_nettype none

package rv32i_types_pkg;

    // Major opcode field, instruction bits [6:0]
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    // ALU funct3 codes for the register-register form
    typedef enum logic [2:0] {
        ADDSUB = 3'b000,
        SLL    = 3'b001,
        SLT    = 3'b010,
        SLTU   = 3'b011,
        XOR    = 3'b100,
        SR     = 3'b101,
        OR     = 3'b110,
        AND    = 3'b111
    } funct3_alu_t;

    // Immediate forms reuse the same codes
    localparam funct3_alu_t ADDI  = ADDSUB;
    localparam funct3_alu_t SLLI  = SLL;
    localparam funct3_alu_t SLTI  = SLT;
    localparam funct3_alu_t SLTIU = SLTU;
    localparam funct3_alu_t XORI  = XOR;
    localparam funct3_alu_t SRI   = SR;
    localparam funct3_alu_t ORI   = OR;
    localparam funct3_alu_t ANDI  = AND;

    typedef struct packed {
        logic [6:0]  funct7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        funct3_alu_t funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] imm11_00;
        logic [4:0]  rs1;
        funct3_alu_t funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } itype_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } utype_t;

    // Encoding of jal x0, 0 which jumps to itself and ends the program
    localparam logic [31:0] HALT_INSN = 32'h0000_006f;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rv32i_exec_pipe.f \
    --top-module tb_rv32i_exec_pipe -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// ==== rv32i_exec_pipe.f ====
hw/rv32i_types_pkg.sv
hw/alu_types_pkg.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/issue_stage.sv
hw/execute_stage.sv
hw/rv32i_exec_pipe.sv
tb/tb_rv32i_exec_pipe.sv

// ==== tb/tb_rv32i_exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_exec_pipe
    import rv32i_types_pkg::*;
();

    localparam int DRV_DLY = 10;
    localparam int N_ALU   = 240;
    localparam int N_FWD   = 16;
    localparam int N_UJ    = 16;
    localparam int N_X0    = 8;
    localparam int N_ILL   = 12;
    // Issue slots of all tests plus reset, drains and margin
    localparam int TIMEOUT_CYCLES = 5 + 8 + 2 * 31 + 2 * N_ALU + 6 * N_FWD + 4 * N_UJ
                                  + 4 * N_X0 + 8 * N_ILL + 7 * 10 + 100;

    // Expected write-back beat
    typedef struct packed {
        logic [31:0] cyc;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] data;
        logic        illegal;
        logic        halt;
    } exp_t;

    logic        clk;
    logic        rst_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        wb_valid_o;
    logic        wb_wen_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        illegal_o;
    logic        halt_o;

    logic [31:0] lfsr = 32'h84bba6da;
    logic [31:0] regs [0:31];
    logic [31:0] pc_cnt;
    exp_t        exp_q [$];
    int          cycle = 0;
    int          errors = 0;
    int          beats = 0;
    int          tests_run = 0;

    rv32i_exec_pipe uut (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_valid_o    (wb_valid_o),
        .wb_wen_o      (wb_wen_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .illegal_o     (illegal_o),
        .halt_o        (halt_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Taps 32, 22, 2, 1; one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] reg_insn(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] imm_insn(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] upper_insn(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // k picks funct3 and form so every operation comes up in turn
    function automatic logic [31:0] rand_alu(input int k);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [6:0]  f7;
        f3 = 3'(k);
        rd = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        if (k[3]) begin
            if (f3 == 3'd1) begin
                imm = {7'd0, rs2};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, 1'(rand_bits(1)), 5'd0, rs2};
            end else begin
                imm = 12'(rand_bits(12));
            end
            return imm_insn(imm, rs1, f3, rd, IMMED);
        end
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) == 1) ? 7'h20 : 7'h00;
        return reg_insn(f7, rs2, rs1, f3, rd, REGREG);
    endfunction

    // RV32I operation by funct3 with alt selecting SUB and SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: begin
                if (alt) return a - b;
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic exp_t ref_model(input logic [31:0] ins, input logic [31:0] pc);
        exp_t        e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [2:0]  f3;
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'd0};
        f3 = ins[14:12];
        e = '0;
        e.rd = ins[11:7];
        // Halt is a JAL with zero offset that links to x0
        e.halt = (ins[6:0] == JAL) && (ins[31:7] == 25'd0);
        e.wen = 1'b1;
        case (ins[6:0])
            LUI:       e.data = imm_u;
            AUIPC:     e.data = pc + imm_u;
            JAL, JALR: e.data = pc + 32'd4;
            IMMED:     e.data = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
            REGREG: begin
                e.data = alu_ref(f3, ins[30], a, b);
                e.illegal = ins[25];
            end
            BRANCH, LOAD, STORE, MISCMEM, SYSTEM: e.wen = 1'b0;
            default: begin
                e.wen = 1'b0;
                e.illegal = 1'b1;
            end
        endcase
        // Neither x0 nor the target of an illegal word is written
        if (e.rd == 5'd0 || e.illegal) e.wen = 1'b0;
        return e;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    // Model state moves in program order at issue
    task automatic issue(input logic [31:0] ins);
        exp_t e;
        e = ref_model(ins, pc_cnt);
        e.cyc = 32'(cycle);
        if (e.wen) regs[e.rd] = e.data;
        exp_q.push_back(e);
        instr_valid_i = 1'b1;
        instr_i = ins;
        pc_i = pc_cnt;
        pc_cnt = pc_cnt + 32'd4;
        @(posedge clk);
        #DRV_DLY;
        instr_valid_i = 1'b0;
    endtask

    // Garbage on the bus while the strobe is low
    task automatic bubble();
        instr_valid_i = 1'b0;
        instr_i = rand_bits(32);
        pc_i = rand_bits(32);
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic finish_test(input string name, input int err0, input int beats0);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #DRV_DLY;
        tests_run++;
        $display("Test %s: %0d beats, %0d errors", name, beats - beats0, errors - err0);
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        exp_t e;
        if (!rst_i) begin
            if (!wb_valid_o) begin
                check("idle wb_wen_o", 32'(wb_wen_o), 32'd0);
                check("idle illegal_o", 32'(illegal_o), 32'd0);
                check("idle halt_o", 32'(halt_o), 32'd0);
            end else if (exp_q.size() == 0) begin
                $display("Output beat at %0t ns with no instruction in flight", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                beats++;
                check("latency", 32'(cycle) - e.cyc, 32'd2);
                check("wb_rd_o", 32'(wb_rd_o), 32'(e.rd));
                check("wb_wen_o", 32'(wb_wen_o), 32'(e.wen));
                check("illegal_o", 32'(illegal_o), 32'(e.illegal));
                check("halt_o", 32'(halt_o), 32'(e.halt));
                if (e.wen) check("wb_data_o", wb_data_o, e.data);
            end
        end
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int         err0;
        int         beats0;
        logic [4:0] r;
        logic [4:0] s;
        logic [4:0] t;
        rst_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        pc_cnt = '0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        repeat (5) @(posedge clk);
        #DRV_DLY;
        rst_i = 1'b0;

        err0 = errors;
        beats0 = beats;
        repeat (8) bubble();
        finish_test("reset_idle", err0, beats0);

        // Random values in every register with ADDI reading the LUI result directly
        err0 = errors;
        beats0 = beats;
        for (int k = 1; k < 32; k++) begin
            issue(upper_insn(20'(rand_bits(20)), 5'(k), LUI));
            issue(imm_insn(12'(rand_bits(12)), 5'(k), ADDI, 5'(k), IMMED));
        end
        finish_test("load_regs", err0, beats0);

        err0 = errors;
        beats0 = beats;
        for (int k = 0; k < N_ALU; k++) begin
            if (rand_bits(2) == 0) bubble();
            issue(rand_alu(k));
        end
        finish_test("alu_ops", err0, beats0);

        err0 = errors;
        beats0 = beats;
        for (int k = 0; k < N_FWD; k++) begin
            r = 5'd1 + 5'(rand_bits(4));
            s = r + 5'd8;
            t = r + 5'd15;
            issue(imm_insn(12'(rand_bits(12)), r, ADDI, r, IMMED));
            issue(reg_insn(7'h00, r, r, ADDSUB, s, REGREG));
            issue(imm_insn(12'(rand_bits(12)), r, XORI, t, IMMED));
            issue(reg_insn(7'h20, s, t, ADDSUB, r, REGREG));
            bubble();
            issue(reg_insn(7'h00, r, s, SLT, t, REGREG));
        end
        finish_test("forwarding", err0, beats0);

        err0 = errors;
        beats0 = beats;
        for (int k = 0; k < N_UJ; k++) begin
            pc_cnt = {30'(rand_bits(30)), 2'b00};
            issue(upper_insn(20'(rand_bits(20)), 5'(rand_bits(5)), LUI));
            issue(upper_insn(20'(rand_bits(20)), 5'(rand_bits(5)), AUIPC));
            issue(upper_insn(20'(rand_bits(20)), 5'(rand_bits(5)), JAL));
            issue(imm_insn(12'(rand_bits(12)), 5'(rand_bits(5)), 3'd0,
                           5'(rand_bits(5)), JALR));
        end
        finish_test("upper_jump", err0, beats0);

        // Reads of x0 right after writes that target it
        err0 = errors;
        beats0 = beats;
        for (int k = 0; k < N_X0; k++) begin
            issue(imm_insn(12'(rand_bits(12)), 5'(rand_bits(5)), ADDI, 5'd0, IMMED));
            issue(upper_insn(20'(rand_bits(20)), 5'd0, LUI));
            issue(reg_insn(7'h00, 5'd0, 5'd0, ADDSUB, 5'd1 + 5'(rand_bits(4)), REGREG));
            issue(imm_insn(12'(rand_bits(12)), 5'd0, ORI, 5'd1 + 5'(rand_bits(4)), IMMED));
        end
        finish_test("x0_writes", err0, beats0);

        err0 = errors;
        beats0 = beats;
        for (int k = 0; k < N_ILL; k++) begin
            r = 5'd1 + 5'(rand_bits(4));
            issue({25'(rand_bits(25)), 7'h7f});
            issue(reg_insn(7'h01, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'(rand_bits(3)),
                           r, REGREG));
            // Target of the illegal word must still hold its old value
            issue(reg_insn(7'h00, 5'd0, r, ADDSUB, r + 5'd15, REGREG));
            // jal x0, 0
            issue(upper_insn(20'd0, 5'd0, JAL));
            issue({25'(rand_bits(25)), BRANCH});
            issue({25'(rand_bits(25)), LOAD});
            issue({25'(rand_bits(25)), STORE});
            issue({25'(rand_bits(25)), SYSTEM});
        end
        finish_test("illegal_halt", err0, beats0);

        $display("Tests run %0d, beats checked %0d, errors %0d", tests_run, beats, errors);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
